// File: hdl/mini_mcu_pkg.sv
////////////////////////////////////////
// memory map of the MCU shell, all targets answer in one cycle
// peripheral windows decode only their low 12 address bits
////////////////////////////////////////

package mini_mcu_pkg;

  // bus widths
  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned BE_WIDTH = DATA_WIDTH / 8;

  // ram window
  localparam logic [ADDR_WIDTH-1:0] RAM_START_ADDRESS = 32'h0000_0000;
  localparam logic [ADDR_WIDTH-1:0] RAM_SIZE = 32'h0000_1000;
  localparam int unsigned RAM_NUM_WORDS = RAM_SIZE / BE_WIDTH;
  localparam int unsigned RAM_IDX_WIDTH = $clog2(RAM_NUM_WORDS);

  // peripheral windows
  localparam logic [ADDR_WIDTH-1:0] AO_PERIPH_START_ADDRESS = 32'h2000_0000;
  localparam logic [ADDR_WIDTH-1:0] PERIPH_START_ADDRESS = 32'h3000_0000;
  localparam logic [ADDR_WIDTH-1:0] PERIPH_SIZE = 32'h0000_1000;
  localparam int unsigned OFFSET_WIDTH = $clog2(PERIPH_SIZE);

  // soc control registers
  localparam logic [OFFSET_WIDTH-1:0] EXIT_VALID_OFFSET = 'h0;
  localparam logic [OFFSET_WIDTH-1:0] EXIT_VALUE_OFFSET = 'h4;
  localparam logic [OFFSET_WIDTH-1:0] BOOT_SELECT_OFFSET = 'h8;

  // gpio registers
  localparam logic [OFFSET_WIDTH-1:0] GPIO_OUT_OFFSET = 'h0;
  localparam logic [OFFSET_WIDTH-1:0] GPIO_EN_OFFSET = 'h4;
  localparam logic [OFFSET_WIDTH-1:0] GPIO_IN_OFFSET = 'h8;
  localparam logic [OFFSET_WIDTH-1:0] GPIO_INTR_STATUS_OFFSET = 'hC;

  localparam int unsigned NUM_GPIO = 32;

  // source of the response in flight
  typedef enum logic [1:0] {
    SLV_RAM,
    SLV_AO,
    SLV_PERIPH,
    SLV_NONE
  } slave_idx_e;

  localparam logic [DATA_WIDTH-1:0] BUS_ERR_DATA = 32'hbad0_0bad;

endpackage

// File: hdl/system_bus.sv
////////////////////////////////////////
// single master hub, no grant and no back-pressure
// targets must answer exactly one cycle after the request
////////////////////////////////////////

module system_bus (
  input  logic                                  clk_i,
  input  logic                                  arst_n_i,
  // master side
  input  logic                                  req_i,
  input  logic [mini_mcu_pkg::ADDR_WIDTH-1:0]   addr_i,
  input  logic                                  we_i,
  input  logic [mini_mcu_pkg::BE_WIDTH-1:0]     be_i,
  input  logic [mini_mcu_pkg::DATA_WIDTH-1:0]   wdata_i,
  output logic                                  rvalid_o,
  output logic [mini_mcu_pkg::DATA_WIDTH-1:0]   rdata_o,
  // ram
  output logic                                  ram_req_o,
  output logic [mini_mcu_pkg::ADDR_WIDTH-1:0]   ram_addr_o,
  output logic                                  ram_we_o,
  output logic [mini_mcu_pkg::BE_WIDTH-1:0]     ram_be_o,
  output logic [mini_mcu_pkg::DATA_WIDTH-1:0]   ram_wdata_o,
  input  logic                                  ram_rvalid_i,
  input  logic [mini_mcu_pkg::DATA_WIDTH-1:0]   ram_rdata_i,
  // always-on peripherals
  output logic                                  ao_req_o,
  output logic [mini_mcu_pkg::ADDR_WIDTH-1:0]   ao_addr_o,
  output logic                                  ao_we_o,
  output logic [mini_mcu_pkg::BE_WIDTH-1:0]     ao_be_o,
  output logic [mini_mcu_pkg::DATA_WIDTH-1:0]   ao_wdata_o,
  input  logic                                  ao_rvalid_i,
  input  logic [mini_mcu_pkg::DATA_WIDTH-1:0]   ao_rdata_i,
  // peripherals
  output logic                                  periph_req_o,
  output logic [mini_mcu_pkg::ADDR_WIDTH-1:0]   periph_addr_o,
  output logic                                  periph_we_o,
  output logic [mini_mcu_pkg::BE_WIDTH-1:0]     periph_be_o,
  output logic [mini_mcu_pkg::DATA_WIDTH-1:0]   periph_wdata_o,
  input  logic                                  periph_rvalid_i,
  input  logic [mini_mcu_pkg::DATA_WIDTH-1:0]   periph_rdata_i
);

  mini_mcu_pkg::slave_idx_e sel;
  mini_mcu_pkg::slave_idx_e sel_q;
  logic err_q;
  logic err_rd_q;

  // window match by offset from base, so a zero base needs no special case
  always_comb begin
    if ((addr_i - mini_mcu_pkg::RAM_START_ADDRESS) < mini_mcu_pkg::RAM_SIZE) begin
      sel = mini_mcu_pkg::SLV_RAM;
    end else if ((addr_i - mini_mcu_pkg::AO_PERIPH_START_ADDRESS) <
                 mini_mcu_pkg::PERIPH_SIZE) begin
      sel = mini_mcu_pkg::SLV_AO;
    end else if ((addr_i - mini_mcu_pkg::PERIPH_START_ADDRESS) <
                 mini_mcu_pkg::PERIPH_SIZE) begin
      sel = mini_mcu_pkg::SLV_PERIPH;
    end else begin
      sel = mini_mcu_pkg::SLV_NONE;
    end
  end

  assign ram_req_o = req_i && (sel == mini_mcu_pkg::SLV_RAM);
  assign ao_req_o = req_i && (sel == mini_mcu_pkg::SLV_AO);
  assign periph_req_o = req_i && (sel == mini_mcu_pkg::SLV_PERIPH);

  assign ram_addr_o = addr_i;
  assign ram_we_o = we_i;
  assign ram_be_o = be_i;
  assign ram_wdata_o = wdata_i;
  assign ao_addr_o = addr_i;
  assign ao_we_o = we_i;
  assign ao_be_o = be_i;
  assign ao_wdata_o = wdata_i;
  assign periph_addr_o = addr_i;
  assign periph_we_o = we_i;
  assign periph_be_o = be_i;
  assign periph_wdata_o = wdata_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sel_q <= mini_mcu_pkg::SLV_NONE;
      err_q <= 1'b0;
      err_rd_q <= 1'b0;
    end else begin
      sel_q <= req_i ? sel : mini_mcu_pkg::SLV_NONE;
      err_q <= req_i && (sel == mini_mcu_pkg::SLV_NONE);
      err_rd_q <= !we_i;
    end
  end

  always_comb begin
    case (sel_q)
      mini_mcu_pkg::SLV_RAM: begin
        rvalid_o = ram_rvalid_i;
        rdata_o = ram_rdata_i;
      end
      mini_mcu_pkg::SLV_AO: begin
        rvalid_o = ao_rvalid_i;
        rdata_o = ao_rdata_i;
      end
      mini_mcu_pkg::SLV_PERIPH: begin
        rvalid_o = periph_rvalid_i;
        rdata_o = periph_rdata_i;
      end
      default: begin
        rvalid_o = err_q;
        rdata_o = err_rd_q ? mini_mcu_pkg::BUS_ERR_DATA : '0;
      end
    endcase
  end

  // a target may only answer the request it took on the previous edge
  ram_resp_a : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    ram_rvalid_i |-> $past(ram_req_o));
  ao_resp_a : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    ao_rvalid_i |-> $past(ao_req_o));
  periph_resp_a : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    periph_rvalid_i |-> $past(periph_req_o));
  master_resp_a : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rvalid_o |-> $past(req_i));

endmodule

// File: hdl/memory_subsystem.sv
////////////////////////////////////////
// single-port word RAM, contents undefined after power-up
// address bits 1:0 are ignored
////////////////////////////////////////

module memory_subsystem (
  input  logic                                  clk_i,
  input  logic                                  arst_n_i,
  input  logic                                  req_i,
  input  logic [mini_mcu_pkg::ADDR_WIDTH-1:0]   addr_i,
  input  logic                                  we_i,
  input  logic [mini_mcu_pkg::BE_WIDTH-1:0]     be_i,
  input  logic [mini_mcu_pkg::DATA_WIDTH-1:0]   wdata_i,
  output logic                                  rvalid_o,
  output logic [mini_mcu_pkg::DATA_WIDTH-1:0]   rdata_o
);

  logic [mini_mcu_pkg::DATA_WIDTH-1:0] mem [mini_mcu_pkg::RAM_NUM_WORDS];
  logic [mini_mcu_pkg::RAM_IDX_WIDTH-1:0] idx;
  logic rvalid_q;

  assign idx = addr_i[mini_mcu_pkg::RAM_IDX_WIDTH+1:2];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int i = 0; i < mini_mcu_pkg::BE_WIDTH; i++) begin
          if (be_i[i]) begin
            mem[idx][8*i +: 8] <= wdata_i[8*i +: 8];
          end
        end
        // writes answer with zero
        rdata_o <= '0;
      end else begin
        rdata_o <= mem[idx];
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i;
    end
  end

  assign rvalid_o = rvalid_q;

  // the bus must never route an outside address here
  in_window_a : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    req_i |-> ((addr_i - mini_mcu_pkg::RAM_START_ADDRESS) < mini_mcu_pkg::RAM_SIZE));

endmodule

// File: hdl/ao_peripheral_subsystem.sv
////////////////////////////////////////
// soc control, exit valid is sticky until reset
// boot select is sampled once, right after reset release
////////////////////////////////////////

module ao_peripheral_subsystem (
  input  logic                                  clk_i,
  input  logic                                  arst_n_i,
  input  logic                                  req_i,
  input  logic [mini_mcu_pkg::ADDR_WIDTH-1:0]   addr_i,
  input  logic                                  we_i,
  input  logic [mini_mcu_pkg::DATA_WIDTH-1:0]   wdata_i,
  output logic                                  rvalid_o,
  output logic [mini_mcu_pkg::DATA_WIDTH-1:0]   rdata_o,
  input  logic                                  boot_select_i,
  output logic [mini_mcu_pkg::DATA_WIDTH-1:0]   exit_value_o,
  output logic                                  exit_valid_o
);

  logic [mini_mcu_pkg::OFFSET_WIDTH-1:0] offset;
  logic wr;
  logic [mini_mcu_pkg::DATA_WIDTH-1:0] exit_value_q;
  logic exit_valid_q;
  logic boot_select_q;
  logic boot_sampled_q;
  logic rvalid_q;

  assign offset = addr_i[mini_mcu_pkg::OFFSET_WIDTH-1:0];
  assign wr = req_i && we_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      exit_value_q <= '0;
      exit_valid_q <= 1'b0;
      boot_select_q <= 1'b0;
      boot_sampled_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i;
      if (!boot_sampled_q) begin
        boot_select_q <= boot_select_i;
        boot_sampled_q <= 1'b1;
      end
      if (wr && (offset == mini_mcu_pkg::EXIT_VALUE_OFFSET)) begin
        exit_value_q <= wdata_i;
      end
      // only a set is possible, a zero write is ignored
      if (wr && (offset == mini_mcu_pkg::EXIT_VALID_OFFSET) && wdata_i[0]) begin
        exit_valid_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_o <= '0;
      if (!we_i) begin
        case (offset)
          mini_mcu_pkg::EXIT_VALID_OFFSET: rdata_o[0] <= exit_valid_q;
          mini_mcu_pkg::EXIT_VALUE_OFFSET: rdata_o <= exit_value_q;
          mini_mcu_pkg::BOOT_SELECT_OFFSET: rdata_o[0] <= boot_select_q;
          default: rdata_o <= '0;
        endcase
      end
    end
  end

  assign rvalid_o = rvalid_q;
  assign exit_value_o = exit_value_q;
  assign exit_valid_o = exit_valid_q;

  exit_sticky_a : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !$fell(exit_valid_o));

endmodule

// File: hdl/peripheral_subsystem.sv
////////////////////////////////////////
// gpio block, full-word access only
// pin inputs pass a two-flop synchronizer before edge detection
////////////////////////////////////////

module peripheral_subsystem (
  input  logic                                  clk_i,
  input  logic                                  arst_n_i,
  input  logic                                  req_i,
  input  logic [mini_mcu_pkg::ADDR_WIDTH-1:0]   addr_i,
  input  logic                                  we_i,
  input  logic [mini_mcu_pkg::DATA_WIDTH-1:0]   wdata_i,
  output logic                                  rvalid_o,
  output logic [mini_mcu_pkg::DATA_WIDTH-1:0]   rdata_o,
  input  logic [mini_mcu_pkg::NUM_GPIO-1:0]     gpio_in_i,
  output logic [mini_mcu_pkg::NUM_GPIO-1:0]     gpio_out_o,
  output logic [mini_mcu_pkg::NUM_GPIO-1:0]     gpio_en_o,
  output logic                                  gpio_irq_o
);

  logic [mini_mcu_pkg::OFFSET_WIDTH-1:0] offset;
  logic wr;
  logic [mini_mcu_pkg::NUM_GPIO-1:0] gpio_out_q;
  logic [mini_mcu_pkg::NUM_GPIO-1:0] gpio_en_q;
  logic [mini_mcu_pkg::NUM_GPIO-1:0] sync_q;
  logic [mini_mcu_pkg::NUM_GPIO-1:0] in_q;
  logic [mini_mcu_pkg::NUM_GPIO-1:0] in_prev_q;
  logic [mini_mcu_pkg::NUM_GPIO-1:0] intr_status_q;
  logic [mini_mcu_pkg::NUM_GPIO-1:0] intr_set;
  logic [mini_mcu_pkg::NUM_GPIO-1:0] intr_clr;
  logic rvalid_q;

  assign offset = addr_i[mini_mcu_pkg::OFFSET_WIDTH-1:0];
  assign wr = req_i && we_i;

  // rising edges of the synchronized pins
  assign intr_set = in_q & ~in_prev_q;
  assign intr_clr = (wr && (offset == mini_mcu_pkg::GPIO_INTR_STATUS_OFFSET)) ? wdata_i : '0;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      gpio_out_q <= '0;
      gpio_en_q <= '0;
      sync_q <= '0;
      in_q <= '0;
      in_prev_q <= '0;
      intr_status_q <= '0;
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i;
      sync_q <= gpio_in_i;
      in_q <= sync_q;
      in_prev_q <= in_q;
      // set has priority over a clear in the same cycle
      intr_status_q <= (intr_status_q & ~intr_clr) | intr_set;
      if (wr && (offset == mini_mcu_pkg::GPIO_OUT_OFFSET)) begin
        gpio_out_q <= wdata_i;
      end
      if (wr && (offset == mini_mcu_pkg::GPIO_EN_OFFSET)) begin
        gpio_en_q <= wdata_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        rdata_o <= '0;
      end else begin
        case (offset)
          mini_mcu_pkg::GPIO_OUT_OFFSET: rdata_o <= gpio_out_q;
          mini_mcu_pkg::GPIO_EN_OFFSET: rdata_o <= gpio_en_q;
          mini_mcu_pkg::GPIO_IN_OFFSET: rdata_o <= in_q;
          mini_mcu_pkg::GPIO_INTR_STATUS_OFFSET: rdata_o <= intr_status_q;
          default: rdata_o <= '0;
        endcase
      end
    end
  end

  assign rvalid_o = rvalid_q;
  assign gpio_out_o = gpio_out_q;
  assign gpio_en_o = gpio_en_q;
  assign gpio_irq_o = |intr_status_q;

endmodule

// File: hdl/mini_mcu.sv
////////////////////////////////////////
// mcu shell driven by one external bus master
// undriven gpio pads float, an outside pull is expected
////////////////////////////////////////

module mini_mcu (
  input  logic                                  clk_i,
  input  logic                                  arst_n_i,
  input  logic                                  ext_master_req_i,
  input  logic [mini_mcu_pkg::ADDR_WIDTH-1:0]   ext_master_addr_i,
  input  logic                                  ext_master_we_i,
  input  logic [mini_mcu_pkg::BE_WIDTH-1:0]     ext_master_be_i,
  input  logic [mini_mcu_pkg::DATA_WIDTH-1:0]   ext_master_wdata_i,
  output logic                                  ext_master_rvalid_o,
  output logic [mini_mcu_pkg::DATA_WIDTH-1:0]   ext_master_rdata_o,
  input  logic                                  boot_select_i,
  output logic [mini_mcu_pkg::DATA_WIDTH-1:0]   exit_value_o,
  output logic                                  exit_valid_o,
  output logic                                  gpio_irq_o,
  inout  wire  [mini_mcu_pkg::NUM_GPIO-1:0]     gpio_io
);

  logic                                ram_req;
  logic [mini_mcu_pkg::ADDR_WIDTH-1:0] ram_addr;
  logic                                ram_we;
  logic [mini_mcu_pkg::BE_WIDTH-1:0]   ram_be;
  logic [mini_mcu_pkg::DATA_WIDTH-1:0] ram_wdata;
  logic                                ram_rvalid;
  logic [mini_mcu_pkg::DATA_WIDTH-1:0] ram_rdata;

  logic                                ao_req;
  logic [mini_mcu_pkg::ADDR_WIDTH-1:0] ao_addr;
  logic                                ao_we;
  logic [mini_mcu_pkg::DATA_WIDTH-1:0] ao_wdata;
  logic                                ao_rvalid;
  logic [mini_mcu_pkg::DATA_WIDTH-1:0] ao_rdata;

  logic                                periph_req;
  logic [mini_mcu_pkg::ADDR_WIDTH-1:0] periph_addr;
  logic                                periph_we;
  logic [mini_mcu_pkg::DATA_WIDTH-1:0] periph_wdata;
  logic                                periph_rvalid;
  logic [mini_mcu_pkg::DATA_WIDTH-1:0] periph_rdata;

  logic [mini_mcu_pkg::NUM_GPIO-1:0]   gpio_in;
  logic [mini_mcu_pkg::NUM_GPIO-1:0]   gpio_out;
  logic [mini_mcu_pkg::NUM_GPIO-1:0]   gpio_en;

  system_bus system_bus_i (
    .clk_i,
    .arst_n_i,
    .req_i(ext_master_req_i),
    .addr_i(ext_master_addr_i),
    .we_i(ext_master_we_i),
    .be_i(ext_master_be_i),
    .wdata_i(ext_master_wdata_i),
    .rvalid_o(ext_master_rvalid_o),
    .rdata_o(ext_master_rdata_o),
    .ram_req_o(ram_req),
    .ram_addr_o(ram_addr),
    .ram_we_o(ram_we),
    .ram_be_o(ram_be),
    .ram_wdata_o(ram_wdata),
    .ram_rvalid_i(ram_rvalid),
    .ram_rdata_i(ram_rdata),
    .ao_req_o(ao_req),
    .ao_addr_o(ao_addr),
    .ao_we_o(ao_we),
    .ao_be_o(),
    .ao_wdata_o(ao_wdata),
    .ao_rvalid_i(ao_rvalid),
    .ao_rdata_i(ao_rdata),
    .periph_req_o(periph_req),
    .periph_addr_o(periph_addr),
    .periph_we_o(periph_we),
    .periph_be_o(),
    .periph_wdata_o(periph_wdata),
    .periph_rvalid_i(periph_rvalid),
    .periph_rdata_i(periph_rdata)
  );

  memory_subsystem memory_subsystem_i (
    .clk_i,
    .arst_n_i,
    .req_i(ram_req),
    .addr_i(ram_addr),
    .we_i(ram_we),
    .be_i(ram_be),
    .wdata_i(ram_wdata),
    .rvalid_o(ram_rvalid),
    .rdata_o(ram_rdata)
  );

  ao_peripheral_subsystem ao_peripheral_subsystem_i (
    .clk_i,
    .arst_n_i,
    .req_i(ao_req),
    .addr_i(ao_addr),
    .we_i(ao_we),
    .wdata_i(ao_wdata),
    .rvalid_o(ao_rvalid),
    .rdata_o(ao_rdata),
    .boot_select_i,
    .exit_value_o,
    .exit_valid_o
  );

  peripheral_subsystem peripheral_subsystem_i (
    .clk_i,
    .arst_n_i,
    .req_i(periph_req),
    .addr_i(periph_addr),
    .we_i(periph_we),
    .wdata_i(periph_wdata),
    .rvalid_o(periph_rvalid),
    .rdata_o(periph_rdata),
    .gpio_in_i(gpio_in),
    .gpio_out_o(gpio_out),
    .gpio_en_o(gpio_en),
    .gpio_irq_o
  );

  // tristate pads, input always follows the pin
  for (genvar i = 0; i < mini_mcu_pkg::NUM_GPIO; i++) begin : gen_gpio_pad
    assign gpio_io[i] = gpio_en[i] ? gpio_out[i] : 1'bz;
  end

  assign gpio_in = gpio_io;

endmodule

// File: verification/mini_mcu_tb.sv
////////////////////////////////////////
// run from the project root, reads verification/mini_mcu_tests.txt
// gpio pads are pulled low wherever nothing drives them
////////////////////////////////////////

module mini_mcu_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned BUS_TIMEOUT = 20;
  localparam int unsigned PIN_TIMEOUT = 10;

  logic                                clk_i;
  logic                                arst_n_i;
  logic                                ext_master_req_i;
  logic [mini_mcu_pkg::ADDR_WIDTH-1:0] ext_master_addr_i;
  logic                                ext_master_we_i;
  logic [mini_mcu_pkg::BE_WIDTH-1:0]   ext_master_be_i;
  logic [mini_mcu_pkg::DATA_WIDTH-1:0] ext_master_wdata_i;
  logic                                ext_master_rvalid_o;
  logic [mini_mcu_pkg::DATA_WIDTH-1:0] ext_master_rdata_o;
  logic                                boot_select_i;
  logic [mini_mcu_pkg::DATA_WIDTH-1:0] exit_value_o;
  logic                                exit_valid_o;
  logic                                gpio_irq_o;
  wire  [mini_mcu_pkg::NUM_GPIO-1:0]   gpio_io;

  logic [mini_mcu_pkg::NUM_GPIO-1:0]   pin_value;
  logic [mini_mcu_pkg::NUM_GPIO-1:0]   pin_mask;
  logic [31:0]                         burst_addr[$];
  logic [31:0]                         burst_exp[$];
  int checks = 0;
  int mismatches = 0;
  int timeouts = 0;
  int file_errors = 0;

  mini_mcu mini_mcu_inst (
    .clk_i,
    .arst_n_i,
    .ext_master_req_i,
    .ext_master_addr_i,
    .ext_master_we_i,
    .ext_master_be_i,
    .ext_master_wdata_i,
    .ext_master_rvalid_o,
    .ext_master_rdata_o,
    .boot_select_i,
    .exit_value_o,
    .exit_valid_o,
    .gpio_irq_o,
    .gpio_io
  );

  // testbench side of the pads, only pins in pin_mask are driven
  for (genvar i = 0; i < mini_mcu_pkg::NUM_GPIO; i++) begin : gen_pin
    assign gpio_io[i] = pin_mask[i] ? pin_value[i] : 1'bz;
    pulldown (gpio_io[i]);
  end

  initial clk_i = 1'b0;
  always #10 clk_i = ~clk_i;

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    checks++;
    if (actual !== expected) begin
      mismatches++;
      $display("mismatch at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
    end
  endtask

  // starts and ends on a falling edge
  task automatic bus_access(input logic [31:0] a, input logic w, input logic [3:0] b,
                            input logic [31:0] d, output logic [31:0] data, output logic ok);
    int cycles;
    ext_master_req_i = 1'b1;
    ext_master_addr_i = a;
    ext_master_we_i = w;
    ext_master_be_i = b;
    ext_master_wdata_i = d;
    @(negedge clk_i);
    ext_master_req_i = 1'b0;
    cycles = 1;
    while (ext_master_rvalid_o !== 1'b1 && cycles < BUS_TIMEOUT) begin
      @(negedge clk_i);
      cycles++;
    end
    ok = (ext_master_rvalid_o === 1'b1);
    data = ext_master_rdata_o;
    if (!ok) begin
      timeouts++;
      $display("error at %0t ns: no bus response for address %h within %0d cycles",
               $time, a, BUS_TIMEOUT);
    end
  endtask

  // one read per cycle, each response due exactly one cycle later
  task automatic run_burst();
    int n;
    n = burst_addr.size();
    for (int k = 0; k < n; k++) begin
      ext_master_req_i = 1'b1;
      ext_master_addr_i = burst_addr[k];
      ext_master_we_i = 1'b0;
      ext_master_be_i = 4'hf;
      @(negedge clk_i);
      check_value({31'b0, ext_master_rvalid_o}, 32'd1, $sformatf("burst rvalid %0d", k));
      check_value(ext_master_rdata_o, burst_exp[k], $sformatf("burst read %h", burst_addr[k]));
    end
    ext_master_req_i = 1'b0;
    @(negedge clk_i);
    check_value({31'b0, ext_master_rvalid_o}, 32'd0, "rvalid after burst");
    burst_addr.delete();
    burst_exp.delete();
  endtask

  task automatic run_operation(input logic [63:0] op, input logic [31:0] a,
                               input logic [31:0] d, input logic [3:0] b,
                               input logic [31:0] e);
    logic [31:0] data;
    logic ok;
    int cycles;
    if (op == "write" || op == "read") begin
      bus_access(a, op == "write", b, d, data, ok);
      if (ok) begin
        check_value(data, e, $sformatf("%0s %h", op, a));
      end
    end else if (op == "pread") begin
      burst_addr.push_back(a);
      burst_exp.push_back(e);
    end else if (op == "burst") begin
      run_burst();
    end else if (op == "poll") begin
      bus_access(a, 1'b0, b, 32'h0, data, ok);
      cycles = 1;
      while (ok && data !== e && cycles < PIN_TIMEOUT) begin
        bus_access(a, 1'b0, b, 32'h0, data, ok);
        cycles++;
      end
      if (ok) begin
        check_value(data, e, $sformatf("poll %h", a));
      end
    end else if (op == "pin") begin
      pin_value = a;
      pin_mask = d;
      @(negedge clk_i);
      cycles = 1;
      while (gpio_io !== e && cycles < PIN_TIMEOUT) begin
        @(negedge clk_i);
        cycles++;
      end
      check_value(gpio_io, e, "gpio pads");
    end else if (op == "wait_irq") begin
      @(negedge clk_i);
      cycles = 1;
      while (gpio_irq_o !== e[0] && cycles < PIN_TIMEOUT) begin
        @(negedge clk_i);
        cycles++;
      end
      check_value({31'b0, gpio_irq_o}, e, "gpio irq");
    end else if (op == "exit") begin
      check_value(exit_value_o, d, "exit value");
      check_value({31'b0, exit_valid_o}, e, "exit valid");
    end else begin
      file_errors++;
      $display("error: unknown operation %0s in the test file", op);
    end
  endtask

  initial begin
    logic [63:0] op;
    logic [8*128-1:0] rest;
    logic [31:0] f_addr;
    logic [31:0] f_data;
    logic [31:0] f_be;
    logic [31:0] f_exp;
    int fd;
    int code;
    bit done;

    arst_n_i = 1'b0;
    ext_master_req_i = 1'b0;
    ext_master_addr_i = '0;
    ext_master_we_i = 1'b0;
    ext_master_be_i = '0;
    ext_master_wdata_i = '0;
    boot_select_i = 1'b1;
    pin_value = '0;
    pin_mask = '1;
    repeat (10) @(negedge clk_i);
    arst_n_i = 1'b1;
    repeat (2) @(negedge clk_i);
    // later changes must not reach BOOT_SELECT
    boot_select_i = 1'b0;

    fd = $fopen("verification/mini_mcu_tests.txt", "r");
    done = 1'b0;
    if (fd == 0) begin
      file_errors++;
      $display("error: cannot open verification/mini_mcu_tests.txt");
      done = 1'b1;
    end
    while (!done) begin
      op = '0;
      code = $fscanf(fd, "%s", op);
      if (code != 1) begin
        done = 1'b1;
      end else if (op == "#") begin
        code = $fgets(rest, fd);
      end else begin
        code = $fscanf(fd, "%h %h %h %h", f_addr, f_data, f_be, f_exp);
        if (code != 4) begin
          file_errors++;
          $display("error: incomplete test line after operation %0s", op);
          done = 1'b1;
        end else begin
          run_operation(op, f_addr, f_data, f_be[3:0], f_exp);
        end
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end

    $display("checks %0d, mismatches %0d, timeouts %0d, file errors %0d",
             checks, mismatches, timeouts, file_errors);
    if (mismatches == 0 && timeouts == 0 && file_errors == 0 && checks > 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: verification/mini_mcu_tests.txt
# columns: op addr data be expected, all hex
# pin drives addr on the pins set in data, exit expects data on exit_value and expected on exit_valid
write 00000000 11223344 f 00000000
write 00000004 a5a5a5a5 f 00000000
write 00000008 0badcafe f 00000000
read 00000000 00000000 f 11223344
read 00000004 00000000 f a5a5a5a5
write 00000004 ffffffff 3 00000000
write 00000008 77000000 8 00000000
read 00000004 00000000 f a5a5ffff
read 00000008 00000000 f 77adcafe
pread 00000000 00000000 f 11223344
pread 00000004 00000000 f a5a5ffff
pread 00000008 00000000 f 77adcafe
burst 00000000 00000000 0 00000000
read 10000000 00000000 f bad00bad
write 10000000 12345678 f 00000000
read 00000000 00000000 f 11223344
read 20000008 00000000 f 00000001
exit 00000000 00000000 0 00000000
write 20000004 cafef00d f 00000000
exit 00000000 cafef00d 0 00000000
read 20000004 00000000 f cafef00d
write 20000000 00000001 f 00000000
exit 00000000 cafef00d 0 00000001
read 20000000 00000000 f 00000001
write 20000000 00000000 f 00000000
exit 00000000 cafef00d 0 00000001
pin 00000000 00000000 0 00000000
write 30000000 a5a50000 f 00000000
write 30000004 ffff0000 f 00000000
pin 00001234 0000ffff 0 a5a51234
poll 30000008 00000000 f a5a51234
read 30000000 00000000 f a5a50000
write 3000000c ffffffff f 00000000
wait_irq 00000000 00000000 0 00000000
write 30000008 ffffffff f 00000000
read 30000008 00000000 f a5a51234
pin 0000123c 0000ffff 0 a5a5123c
wait_irq 00000000 00000000 0 00000001
read 3000000c 00000000 f 00000008
write 3000000c 00000008 f 00000000
wait_irq 00000000 00000000 0 00000000
read 3000000c 00000000 f 00000000

// File: build.f
hdl/mini_mcu_pkg.sv
hdl/system_bus.sv
hdl/memory_subsystem.sv
hdl/ao_peripheral_subsystem.sv
hdl/peripheral_subsystem.sv
hdl/mini_mcu.sv
verification/mini_mcu_tb.sv

// File: Bender.yml
package:
  name: mini_mcu

sources:
  - hdl/mini_mcu_pkg.sv
  - hdl/system_bus.sv
  - hdl/memory_subsystem.sv
  - hdl/ao_peripheral_subsystem.sv
  - hdl/peripheral_subsystem.sv
  - hdl/mini_mcu.sv
  - target: simulation
    files:
      - verification/mini_mcu_tb.sv
